// ==== tb.f ====
design/accel_pkg.sv
design/fifo_buffer.sv
design/wb_stream_regs.sv
design/stream_alu_stage.sv
design/stream_accel_top.sv
testbench/tb_stream_accel.sv

// ==== Bender.yml ====
package:
  name: stream_accel

sources:
  # Package first, then leaf modules, then the top level
  - design/accel_pkg.sv
  - design/fifo_buffer.sv
  - design/wb_stream_regs.sv
  - design/stream_alu_stage.sv
  - design/stream_accel_top.sv
  - target: test
    files:
      - testbench/tb_stream_accel.sv

// ==== testbench/tb_stream_accel.sv ====
module tb_stream_accel import accel_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Upper bound of bus operations over all tests including polls
  localparam int unsigned NumBusOps      = 160;
  localparam int unsigned WatchdogCycles = 40 * NumBusOps + 500;
  localparam int unsigned AckTimeout     = 20;
  localparam int unsigned MaxPolls       = 20;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic                   wb_we_i;
  logic [WbAddrWidth-1:0] wb_adr_i;
  logic [31:0]            wb_dat_i;
  logic [31:0]            wb_dat_o;
  logic                   wb_ack_o;

  int          errors;
  int          checks;
  logic [15:0] lfsr_q;

  stream_accel_top DUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  // 50 MHz
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, the run is stuck", WatchdogCycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  // Reference model of the stage
  function automatic logic [31:0] expected_result(input alu_op_e op, input logic [31:0] operand,
                                                  input logic [31:0] data);
    logic [63:0] prod;
    prod = 64'(data) * 64'(operand);
    case (op)
      OP_ADD:  return data + operand;
      OP_MUL:  return prod[31:0];
      OP_XOR:  return data ^ operand;
      default: return data;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
    end
  endtask

  // One Wishbone classic access held through the ack cycle
  task automatic bus_access(input logic we, input logic [WbAddrWidth-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int  waited;
    bit  got_ack;
    waited  = 0;
    got_ack = 1'b0;
    rdata   = '0;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    while (!got_ack && waited < AckTimeout) begin
      @(negedge clk_i);
      waited++;
      if (wb_ack_o) begin
        got_ack = 1'b1;
        rdata   = wb_dat_o;
      end
    end
    if (!got_ack) begin
      errors++;
      $display("ERROR: no ack within %0d cycles for access to offset %0d", AckTimeout, adr);
    end else begin
      // Ack comes in the clock after the request
      check_value("wb_ack_o delay", waited, 1);
      // Access takes effect at the end of the ack cycle
      @(negedge clk_i);
      // Ack lasts a single cycle
      check_value("wb_ack_o", wb_ack_o, 1'b0);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [WbAddrWidth-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WbAddrWidth-1:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, '0, data);
  endtask

  // Poll status until the output count and the words in flight reach their minimum
  task automatic wait_status(input int need_out, input int need_total);
    logic [31:0] stat;
    int          polls;
    int          out_cnt;
    int          total;
    polls = 0;
    do begin
      wb_read(RegStatus, stat);
      polls++;
      out_cnt = stat[StatOutCntLsb +: StatCntWidth];
      total   = out_cnt + stat[StatInCntLsb +: StatCntWidth] + stat[StatBusyBit];
    end while ((out_cnt < need_out || total < need_total) && polls < MaxPolls);
    if (out_cnt < need_out || total < need_total) begin
      errors++;
      $display("ERROR: status never showed %0d output words and %0d in flight", need_out,
               need_total);
    end
  endtask

  // Wait for a word at the output, then pop and compare it
  task automatic pop_checked(input logic [31:0] expected);
    logic [31:0] rdata;
    wait_status(1, 0);
    wb_read(RegDataOut, rdata);
    check_value("wb_dat_o", rdata, expected);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_values();
    logic [31:0] rdata;
    wb_read(RegStatus, rdata);
    check_value("status", rdata, '0);
    wb_read(RegConfig, rdata);
    check_value("config", rdata, 32'(OP_PASS));
    wb_read(RegOperand, rdata);
    check_value("operand", rdata, '0);
  endtask

  task automatic test_pass_order();
    logic [31:0] words[6];
    logic [31:0] rdata;
    wb_write(RegConfig, 32'(OP_PASS));
    foreach (words[i]) begin
      words[i] = rand_word();
      wb_write(RegDataIn, words[i]);
    end
    wait_status(0, 6);
    foreach (words[i]) pop_checked(words[i]);
    // Queues drained and flags still clear
    wb_read(RegStatus, rdata);
    check_value("status", rdata, '0);
  endtask

  task automatic run_opcode(input alu_op_e op);
    logic [31:0] operand;
    logic [31:0] word;
    operand = rand_word();
    wb_write(RegConfig, 32'(op));
    wb_write(RegOperand, operand);
    repeat (3) begin
      word = rand_word();
      wb_write(RegDataIn, word);
      pop_checked(expected_result(op, operand, word));
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] words[15];
    logic [31:0] rdata;
    wb_write(RegConfig, 32'(OP_PASS));
    foreach (words[i]) begin
      words[i] = rand_word();
      wb_write(RegDataIn, words[i]);
    end
    wait_status(4, 13);
    // Input and output full with the stage holding and two writes lost
    wb_read(RegStatus, rdata);
    check_value("status", rdata, 32'h0005_0408);
    // Only the first thirteen survive
    for (int i = 0; i < 13; i++) pop_checked(words[i]);
    wb_read(RegDataOut, rdata);
    check_value("wb_dat_o", rdata, '0);
    wb_read(RegStatus, rdata);
    check_value("status", rdata, 32'h0003_0000);
  endtask

  task automatic test_clear();
    logic [31:0] operand;
    logic [31:0] word;
    logic [31:0] rdata;
    operand = rand_word();
    wb_write(RegConfig, 32'(OP_XOR));
    wb_write(RegOperand, operand);
    // Flags carried over from the overflow test
    wb_write(RegDataIn, rand_word());
    wb_write(RegDataIn, rand_word());
    wait_status(2, 2);
    // Two words queued at the output and both flags still set
    wb_read(RegStatus, rdata);
    check_value("status", rdata, 32'h0003_0200);
    wb_write(RegClear, 32'h1);
    wb_read(RegStatus, rdata);
    check_value("status", rdata, '0);
    wb_read(RegConfig, rdata);
    check_value("config", rdata, 32'(OP_XOR));
    wb_read(RegOperand, rdata);
    check_value("operand", rdata, operand);
    // Pipeline still usable
    word = rand_word();
    wb_write(RegDataIn, word);
    pop_checked(expected_result(OP_XOR, operand, word));
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    errors   = 0;
    checks   = 0;
    lfsr_q   = 16'd14246;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_values();
    test_pass_order();
    run_opcode(OP_ADD);
    run_opcode(OP_MUL);
    run_opcode(OP_XOR);
    test_backpressure();
    test_clear();

    $display("Run finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== design/stream_accel_top.sv ====
module stream_accel_top import accel_pkg::*; #(
  parameter int unsigned DataWidth   = 32,
  parameter int unsigned InDepth     = 8,
  parameter int unsigned OutDepth    = 4,
  parameter bit          FallThrough = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [WbAddrWidth-1:0] wb_adr_i,
  input  logic [DataWidth-1:0]   wb_dat_i,
  output logic [DataWidth-1:0]   wb_dat_o,
  output logic                   wb_ack_o
);

  // Fill counter widths of the two queues
  localparam int unsigned InCntWidth  = ((InDepth > 1) ? $clog2(InDepth) : 1) + 1;
  localparam int unsigned OutCntWidth = ((OutDepth > 1) ? $clog2(OutDepth) : 1) + 1;

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------

  logic                   clr;
  alu_op_e                op;
  logic [DataWidth-1:0]   operand;
  logic                   stage_busy;

  // Front end into input queue
  logic                   in_push;
  logic [DataWidth-1:0]   in_data;
  logic                   in_full;
  logic [InCntWidth-1:0]  in_count;

  // Input queue into stage
  logic [DataWidth-1:0]   in_head;
  logic                   in_empty;
  logic                   in_pop;

  // Stage into output queue
  logic [DataWidth-1:0]   stage_data;
  logic                   out_push;
  logic                   out_full;

  // Output queue back to the front end
  logic [DataWidth-1:0]   out_head;
  logic                   out_empty;
  logic                   out_pop;
  logic [OutCntWidth-1:0] out_count;

  // ----------------------------------------
  // Pipeline
  // ----------------------------------------

  wb_stream_regs #(
    .DataWidth (DataWidth),
    .InDepth   (InDepth),
    .OutDepth  (OutDepth)
  ) u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .clr_o        (clr),
    .in_push_o    (in_push),
    .in_data_o    (in_data),
    .in_full_i    (in_full),
    .in_count_i   (in_count),
    .out_pop_o    (out_pop),
    .out_data_i   (out_head),
    .out_empty_i  (out_empty),
    .out_count_i  (out_count),
    .op_o         (op),
    .operand_o    (operand),
    .stage_busy_i (stage_busy)
  );

  fifo_buffer #(
    .FallThrough (FallThrough),
    .DataWidth   (DataWidth),
    .FifoDepth   (InDepth)
  ) u_in_fifo (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clr_i           (clr),
    .data_i          (in_data),
    .push_i          (in_push),
    .pop_i           (in_pop),
    .full_o          (in_full),
    .empty_o         (in_empty),
    .counter_state_o (in_count),
    .data_o          (in_head)
  );

  stream_alu_stage #(
    .DataWidth (DataWidth)
  ) u_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clr_i      (clr),
    .op_i       (op),
    .operand_i  (operand),
    .in_data_i  (in_head),
    .in_empty_i (in_empty),
    .in_pop_o   (in_pop),
    .out_data_o (stage_data),
    .out_full_i (out_full),
    .out_push_o (out_push),
    .busy_o     (stage_busy)
  );

  fifo_buffer #(
    .FallThrough (FallThrough),
    .DataWidth   (DataWidth),
    .FifoDepth   (OutDepth)
  ) u_out_fifo (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clr_i           (clr),
    .data_i          (stage_data),
    .push_i          (out_push),
    .pop_i           (out_pop),
    .full_o          (out_full),
    .empty_o         (out_empty),
    .counter_state_o (out_count),
    .data_o          (out_head)
  );

endmodule

// ==== design/stream_alu_stage.sv ====
module stream_alu_stage import accel_pkg::*; #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Drops the held word
  input  logic                 clr_i,
  // Live configuration
  input  alu_op_e              op_i,
  input  logic [DataWidth-1:0] operand_i,
  // Input queue side
  input  logic [DataWidth-1:0] in_data_i,
  input  logic                 in_empty_i,
  output logic                 in_pop_o,
  // Output queue side
  output logic [DataWidth-1:0] out_data_o,
  input  logic                 out_full_i,
  output logic                 out_push_o,
  // Held word still waiting
  output logic                 busy_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] result_q;
  logic [DataWidth-1:0] alu_res;
  logic                 drain;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Held word leaves when the output queue has room
  assign drain = valid_q & ~out_full_i;

  // Take a new word if the slot is free or freeing up this cycle
  // No pop during a clear, the queue is being flushed anyway
  assign in_pop_o = ~clr_i & ~in_empty_i & (~valid_q | drain);

  assign out_push_o = valid_q;
  assign out_data_o = result_q;
  assign busy_o     = valid_q;

  // ----------------------------------------
  // Arithmetic
  // ----------------------------------------

  // Opcode and operand sampled at pop time
  always_comb begin : alu
    case (op_i)
      OP_ADD:  alu_res = in_data_i + operand_i;
      // Product truncated to the data width
      OP_MUL:  alu_res = in_data_i * operand_i;
      OP_XOR:  alu_res = in_data_i ^ operand_i;
      default: alu_res = in_data_i;
    endcase
  end

  // ----------------------------------------
  // Result register
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clr_i) begin
      valid_q <= 1'b0;
    end else if (in_pop_o) begin
      // Refill, also covers drain and refill in one cycle
      valid_q <= 1'b1;
    end else if (drain) begin
      valid_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (in_pop_o) begin
      result_q <= alu_res;
    end
  end

endmodule

// ==== design/wb_stream_regs.sv ====
module wb_stream_regs import accel_pkg::*; #(
  parameter int unsigned DataWidth  = 32,
  parameter int unsigned InDepth    = 8,
  parameter int unsigned OutDepth   = 4,
  // Fill counter widths, matching the queue instances
  localparam int unsigned InCntWidth  = ((InDepth > 1) ? $clog2(InDepth) : 1) + 1,
  localparam int unsigned OutCntWidth = ((OutDepth > 1) ? $clog2(OutDepth) : 1) + 1
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Wishbone classic slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [WbAddrWidth-1:0] wb_adr_i,
  input  logic [DataWidth-1:0]   wb_dat_i,
  output logic [DataWidth-1:0]   wb_dat_o,
  output logic                   wb_ack_o,
  // One cycle flush of the datapath
  output logic                   clr_o,
  // Input queue side
  output logic                   in_push_o,
  output logic [DataWidth-1:0]   in_data_o,
  input  logic                   in_full_i,
  input  logic [InCntWidth-1:0]  in_count_i,
  // Output queue side
  output logic                   out_pop_o,
  input  logic [DataWidth-1:0]   out_data_i,
  input  logic                   out_empty_i,
  input  logic [OutCntWidth-1:0] out_count_i,
  // Stage side
  output alu_op_e                op_o,
  output logic [DataWidth-1:0]   operand_o,
  input  logic                   stage_busy_i
);

  typedef enum logic {
    BUS_IDLE,
    BUS_ACK
  } bus_state_e;

  bus_state_e state_q;
  bus_state_e state_d;

  logic                 req;
  logic                 wr_acc;
  logic                 rd_acc;
  logic                 clr_q;
  logic                 ovf_q;
  logic                 udf_q;
  alu_op_e              op_q;
  logic [DataWidth-1:0] operand_q;
  logic [DataWidth-1:0] rdata;

  // ----------------------------------------
  // Bus handshake
  // ----------------------------------------

  assign req = wb_cyc_i & wb_stb_i;

  // Ack one cycle after the request, then back to idle
  // Master drops stb during the ack so no double accept
  always_comb begin : bus_fsm
    state_d = state_q;
    case (state_q)
      BUS_IDLE: if (req) state_d = BUS_ACK;
      BUS_ACK:  state_d = BUS_IDLE;
      default:  state_d = BUS_IDLE;
    endcase
  end

  assign wb_ack_o = (state_q == BUS_ACK);

  // Accesses take effect on the ack cycle, master still holds adr and data
  assign wr_acc = wb_ack_o & wb_we_i;
  assign rd_acc = wb_ack_o & ~wb_we_i;

  // Queue strobes
  assign in_push_o = wr_acc & (wb_adr_i == RegDataIn);
  assign in_data_o = wb_dat_i;
  assign out_pop_o = rd_acc & (wb_adr_i == RegDataOut);

  assign clr_o     = clr_q;
  assign op_o      = op_q;
  assign operand_o = operand_q;

  // ----------------------------------------
  // Read data
  // ----------------------------------------

  always_comb begin : read_mux
    rdata = '0;
    case (wb_adr_i)
      // Empty queue reads as zero
      RegDataOut: if (!out_empty_i) rdata = out_data_i;
      RegStatus: begin
        rdata[StatInCntLsb +: StatCntWidth]  = StatCntWidth'(in_count_i);
        rdata[StatOutCntLsb +: StatCntWidth] = StatCntWidth'(out_count_i);
        rdata[StatOvfBit]                    = ovf_q;
        rdata[StatUdfBit]                    = udf_q;
        rdata[StatBusyBit]                   = stage_busy_i;
      end
      RegConfig:  rdata[$bits(alu_op_e)-1:0] = op_q;
      RegOperand: rdata = operand_q;
      // DataIn, Clear and unmapped offsets read zero
      default:    rdata = '0;
    endcase
  end

  assign wb_dat_o = rd_acc ? rdata : '0;

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= BUS_IDLE;
      clr_q     <= 1'b0;
      ovf_q     <= 1'b0;
      udf_q     <= 1'b0;
      op_q      <= OP_PASS;
      operand_q <= '0;
    end else begin
      state_q <= state_d;
      // Clear fires in the cycle after the ack
      clr_q   <= wr_acc & (wb_adr_i == RegClear);

      // Sticky error flags, only the clear pulse drops them
      if (clr_q) begin
        ovf_q <= 1'b0;
        udf_q <= 1'b0;
      end else begin
        if (in_push_o && in_full_i) ovf_q <= 1'b1;
        if (out_pop_o && out_empty_i) udf_q <= 1'b1;
      end

      // Configuration survives a clear
      if (wr_acc && (wb_adr_i == RegConfig)) begin
        op_q <= alu_op_e'(wb_dat_i[$bits(alu_op_e)-1:0]);
      end
      if (wr_acc && (wb_adr_i == RegOperand)) begin
        operand_q <= wb_dat_i;
      end
    end
  end

endmodule

// ==== design/fifo_buffer.sv ====
module fifo_buffer #(
  parameter bit          FallThrough = 1'b0,
  parameter int unsigned DataWidth   = 32,
  parameter int unsigned FifoDepth   = 8,
  // Pointer width, kept at one bit for a single entry queue
  localparam int unsigned AddrWidth  = (FifoDepth > 1) ? $clog2(FifoDepth) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Synchronous flush of the whole queue
  input  logic                 clr_i,
  input  logic [DataWidth-1:0] data_i,
  input  logic                 push_i,
  input  logic                 pop_i,
  output logic                 full_o,
  output logic                 empty_o,
  // Number of stored words, one bit wider than the pointers
  output logic [AddrWidth:0]   counter_state_o,
  output logic [DataWidth-1:0] data_o
);

  // ----------------------------------------
  // Storage and bookkeeping
  // ----------------------------------------

  logic [AddrWidth-1:0] rd_ptr_q;
  logic [AddrWidth-1:0] rd_ptr_d;
  logic [AddrWidth-1:0] wr_ptr_q;
  logic [AddrWidth-1:0] wr_ptr_d;
  logic [AddrWidth:0]   cnt_q;
  logic [AddrWidth:0]   cnt_d;

  // Queue body
  logic [DataWidth-1:0] mem_q [FifoDepth];

  // Qualified strobes
  logic is_empty;
  logic bypass;
  logic push_ok;
  logic pop_ok;

  // Advance a pointer and wrap at the last entry
  // Needed for depths that are not a power of two
  function automatic logic [AddrWidth-1:0] ptr_inc(input logic [AddrWidth-1:0] ptr);
    if (ptr == AddrWidth'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Flags
  // ----------------------------------------

  assign is_empty        = (cnt_q == '0);
  assign full_o          = (cnt_q == (AddrWidth + 1)'(FifoDepth));
  assign counter_state_o = cnt_q;

  // In fall-through mode an incoming word makes the queue look non-empty
  assign empty_o = is_empty & ~(FallThrough & push_i);

  // Word goes straight from input to output
  // Nothing is stored and no pointer moves
  assign bypass = FallThrough & is_empty & push_i & pop_i;

  // Push on full and pop on empty are dropped
  assign push_ok = push_i & ~full_o & ~bypass;
  assign pop_ok  = pop_i & ~empty_o & ~bypass;

  // Head of queue, or the incoming word while empty in fall-through mode
  assign data_o = (FallThrough && is_empty) ? data_i : mem_q[rd_ptr_q];

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin : next_state
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    cnt_d    = cnt_q;

    if (push_ok) begin
      wr_ptr_d = ptr_inc(wr_ptr_q);
    end

    if (pop_ok) begin
      rd_ptr_d = ptr_inc(rd_ptr_q);
    end

    // Push and pop together leave the count alone
    case ({push_ok, pop_ok})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  // Pointers and fill count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      // Clear wins over any push or pop in the same cycle
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Word store
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== design/accel_pkg.sv ====
package accel_pkg;

  // ----------------------------------------
  // Bus geometry
  // ----------------------------------------

  // Word address width of the register window
  localparam int unsigned WbAddrWidth = 4;

  // ----------------------------------------
  // Register map, word offsets
  // ----------------------------------------

  // Write pushes one word into the input queue
  localparam logic [WbAddrWidth-1:0] RegDataIn  = 4'd0;
  // Read pops the head of the output queue
  localparam logic [WbAddrWidth-1:0] RegDataOut = 4'd1;
  // Fill counters, sticky flags and stage busy
  localparam logic [WbAddrWidth-1:0] RegStatus  = 4'd2;
  // Opcode in the low two bits
  localparam logic [WbAddrWidth-1:0] RegConfig  = 4'd3;
  localparam logic [WbAddrWidth-1:0] RegOperand = 4'd4;
  // Any write fires a one cycle clear
  localparam logic [WbAddrWidth-1:0] RegClear   = 4'd5;

  // Status register layout
  localparam int unsigned StatCntWidth  = 8;
  localparam int unsigned StatInCntLsb  = 0;
  localparam int unsigned StatOutCntLsb = 8;
  localparam int unsigned StatOvfBit    = 16;
  localparam int unsigned StatUdfBit    = 17;
  localparam int unsigned StatBusyBit   = 18;

  // ----------------------------------------
  // Stage operations
  // ----------------------------------------

  typedef enum logic [1:0] {
    OP_PASS = 2'd0,
    OP_ADD  = 2'd1,
    // Low half of the product only
    OP_MUL  = 2'd2,
    OP_XOR  = 2'd3
  } alu_op_e;

endpackage
